//--- include/axi_corebus_consts.svh
// bus widths, queue depths and memory size
// for the axi to corebus bridge and its memory target.

`ifndef AXI_COREBUS_CONSTS_SVH
`define AXI_COREBUS_CONSTS_SVH

// axi side.
`define AXI_ID_W          4
`define AXI_ADDR_W        16
`define AXI_LEN_W         8

// data path and corebus unit.
`define DATA_W            64
`define UNIT_W            32
`define CB_LEN_W          10   // length counted in 32-bit units.

// queue depths.
`define CMD_FIFO_DEPTH    2
`define WDATA_FIFO_DEPTH  2
`define BID_FIFO_DEPTH    8

// memory size in 64-bit words.
`define MEM_WORDS         256

`endif

//--- src/axi_corebus_pkg.sv
// payload types for the axi to corebus bridge.
// axi channel structs, corebus command/data/response structs and encodings.

`include "axi_corebus_consts.svh"

package axi_corebus_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } cb_cmd_e;

  // shared by aw and ar.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
    logic [2:0]             size;
  } axi_ax_t;

  typedef struct packed {
    logic [`DATA_W-1:0]   data;
    logic [`DATA_W/8-1:0] strb;
    logic                 last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    axi_resp_e            resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [`DATA_W-1:0]   data;
    axi_resp_e            resp;
    logic                 last;
  } axi_r_t;

  //======================================================================
  // corebus.
  //======================================================================
  typedef struct packed {
    cb_cmd_e                cmd;
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;    // 4-byte aligned.
    logic [`CB_LEN_W-1:0]   length;  // in units.
  } cb_cmd_t;

  typedef struct packed {
    logic [`DATA_W-1:0]   data;
    logic [`DATA_W/8-1:0] byteen;
    logic                 last;
  } cb_data_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [`DATA_W-1:0]   data;
    logic                 error;
    logic                 last;
  } cb_resp_t;

endpackage

//--- src/bus_fifo.sv
// synchronous fifo with a type-parameter payload.
// flags are registered and read as full/empty during reset.

module bus_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
)(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_push,
  input  payload_t i_data,
  output logic     o_full,
  input  logic     i_pop,
  output payload_t o_data,
  output logic     o_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         ram [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign do_push    = i_push && !o_full;
  assign do_pop     = i_pop && !o_empty;
  assign count_next = count + CNT_W'(do_push) - CNT_W'(do_pop);
  assign o_data     = ram[rd_ptr];

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_full  <= 1'b1;  // not ready until out of reset.
      o_empty <= 1'b1;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      count   <= count_next;
      o_full  <= count_next == CNT_W'(DEPTH);
      o_empty <= count_next == '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) ram[wr_ptr] <= i_data;
  end

endmodule

//--- src/corebus_cmd_arbiter.sv
// two-way round robin between the read and write command queues.
// the grant is held while its command waits for accept.

module corebus_cmd_arbiter
  import axi_corebus_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_rd_valid,
  input  cb_cmd_t i_rd_cmd,
  output logic    o_rd_accept,
  input  logic    i_wr_valid,
  input  cb_cmd_t i_wr_cmd,
  output logic    o_wr_accept,
  output logic    o_cmd_valid,
  output cb_cmd_t o_cmd,
  input  logic    i_cmd_accept
);

  logic last_wr;  // write side won last.
  logic lock;
  logic lock_wr;
  logic sel_wr;
  logic cmd_fire;

  always_comb begin
    if (lock) begin
      sel_wr = lock_wr;
    end else if (i_rd_valid && i_wr_valid) begin
      sel_wr = !last_wr;
    end else begin
      sel_wr = i_wr_valid;
    end
  end

  assign o_cmd_valid = sel_wr ? i_wr_valid : i_rd_valid;
  assign o_cmd       = sel_wr ? i_wr_cmd : i_rd_cmd;
  assign o_rd_accept = !sel_wr && i_cmd_accept;
  assign o_wr_accept = sel_wr && i_cmd_accept;
  assign cmd_fire    = o_cmd_valid && i_cmd_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_wr <= 1'b1;  // read goes first after reset.
      lock    <= 1'b0;
      lock_wr <= 1'b0;
    end else if (cmd_fire) begin
      last_wr <= sel_wr;
      lock    <= 1'b0;
    end else if (o_cmd_valid) begin
      lock    <= 1'b1;
      lock_wr <= sel_wr;
    end
  end

endmodule

//--- src/axi2corebus_bridge.sv
// axi slave to corebus master bridge.
// command and write data queues, round robin command merge,
// locally generated b responses from an id fifo and completion counter.

`include "axi_corebus_consts.svh"

module axi2corebus_bridge
  import axi_corebus_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_aw_valid,
  output logic     o_aw_ready,
  input  axi_ax_t  i_aw,
  input  logic     i_w_valid,
  output logic     o_w_ready,
  input  axi_w_t   i_w,
  output logic     o_b_valid,
  input  logic     i_b_ready,
  output axi_b_t   o_b,
  input  logic     i_ar_valid,
  output logic     o_ar_ready,
  input  axi_ax_t  i_ar,
  output logic     o_r_valid,
  input  logic     i_r_ready,
  output axi_r_t   o_r,
  output logic     o_cmd_valid,
  output cb_cmd_t  o_cmd,
  input  logic     i_cmd_accept,
  output logic     o_data_valid,
  output cb_data_t o_data,
  input  logic     i_data_accept,
  input  logic     i_resp_valid,
  input  cb_resp_t i_resp,
  output logic     o_resp_accept
);

  localparam int CNT_W = $clog2(`BID_FIFO_DEPTH + 1);

  function automatic logic is_4byte(axi_ax_t ax);
    return (ax.len == '0) && (ax.size == 3'd2);
  endfunction

  function automatic logic [`CB_LEN_W-1:0] get_length(axi_ax_t ax);
    logic [`CB_LEN_W-1:0] units;
    units = {`CB_LEN_W'(ax.len) + `CB_LEN_W'(1)} << 1;  // two units per beat.
    if (is_4byte(ax)) begin
      return `CB_LEN_W'(1);
    end
    return units - `CB_LEN_W'(ax.addr[2]);
  endfunction

  function automatic cb_cmd_t make_cmd(cb_cmd_e kind, axi_ax_t ax);
    cb_cmd_t c;
    c.cmd    = kind;
    c.id     = ax.id;
    c.addr   = {ax.addr[`AXI_ADDR_W-1:2], 2'b00};
    c.length = get_length(ax);
    return c;
  endfunction

  cb_cmd_t              rcmd;
  cb_cmd_t              wcmd;
  logic                 rcmd_full, rcmd_empty, rd_accept;
  logic                 wcmd_full, wcmd_empty, wr_accept;
  logic                 wdata_full, wdata_empty;
  logic                 bid_full, bid_empty;
  logic [`AXI_ID_W-1:0] bid;
  logic [CNT_W-1:0]     done_cnt;    // wlast accepted, b not yet sent.
  logic [CNT_W-1:0]     issued_cnt;  // write command passed to memory, b not yet sent.
  logic                 aw_fire, wlast_fire, b_fire, wr_issue;

  //======================================================================
  // read path.
  //======================================================================
  bus_fifo #(.payload_t(cb_cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) u_rcmd_fifo (
    .i_clk, .i_rst_n,
    .i_push  (i_ar_valid && o_ar_ready),
    .i_data  (make_cmd(READ, i_ar)),
    .o_full  (rcmd_full),
    .i_pop   (!rcmd_empty && rd_accept),
    .o_data  (rcmd),
    .o_empty (rcmd_empty)
  );

  assign o_ar_ready    = !rcmd_full;
  assign o_resp_accept = i_r_ready;
  assign o_r_valid     = i_resp_valid;
  assign o_r.id        = i_resp.id;
  assign o_r.data      = i_resp.data;
  assign o_r.resp      = i_resp.error ? SLVERR : OKAY;
  assign o_r.last      = i_resp.last;

  //======================================================================
  // write path.
  //======================================================================
  assign aw_fire    = i_aw_valid && o_aw_ready;
  assign wlast_fire = i_w_valid && o_w_ready && i_w.last;
  assign b_fire     = o_b_valid && i_b_ready;
  assign wr_issue   = !wcmd_empty && wr_accept;

  bus_fifo #(.payload_t(cb_cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) u_wcmd_fifo (
    .i_clk, .i_rst_n,
    .i_push  (aw_fire),
    .i_data  (make_cmd(WRITE, i_aw)),
    .o_full  (wcmd_full),
    .i_pop   (wr_issue),
    .o_data  (wcmd),
    .o_empty (wcmd_empty)
  );

  bus_fifo #(.payload_t(cb_data_t), .DEPTH(`WDATA_FIFO_DEPTH)) u_wdata_fifo (
    .i_clk, .i_rst_n,
    .i_push  (i_w_valid && o_w_ready),
    .i_data  ('{data: i_w.data, byteen: i_w.strb, last: i_w.last}),
    .o_full  (wdata_full),
    .i_pop   (o_data_valid && i_data_accept),
    .o_data  (o_data),
    .o_empty (wdata_empty)
  );

  bus_fifo #(.payload_t(logic [`AXI_ID_W-1:0]), .DEPTH(`BID_FIFO_DEPTH)) u_bid_fifo (
    .i_clk, .i_rst_n,
    .i_push  (aw_fire),
    .i_data  (i_aw.id),
    .o_full  (bid_full),
    .i_pop   (b_fire),
    .o_data  (bid),
    .o_empty (bid_empty)
  );

  assign o_aw_ready   = !bid_full && !wcmd_full;
  assign o_w_ready    = (done_cnt != CNT_W'(`BID_FIFO_DEPTH)) && !wdata_full;
  assign o_data_valid = !wdata_empty;

  // b waits for the memory to take the write, so a later read sees its data.
  assign o_b_valid = !bid_empty && (done_cnt != '0) && (issued_cnt != '0);
  assign o_b.id    = bid;
  assign o_b.resp  = OKAY;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      done_cnt   <= '0;
      issued_cnt <= '0;
    end else begin
      done_cnt   <= done_cnt + CNT_W'(wlast_fire) - CNT_W'(b_fire);
      issued_cnt <= issued_cnt + CNT_W'(wr_issue) - CNT_W'(b_fire);
    end
  end

  corebus_cmd_arbiter u_arbiter (
    .i_clk, .i_rst_n,
    .i_rd_valid   (!rcmd_empty),
    .i_rd_cmd     (rcmd),
    .o_rd_accept  (rd_accept),
    .i_wr_valid   (!wcmd_empty),
    .i_wr_cmd     (wcmd),
    .o_wr_accept  (wr_accept),
    .o_cmd_valid  (o_cmd_valid),
    .o_cmd        (o_cmd),
    .i_cmd_accept (i_cmd_accept)
  );

endmodule

//--- src/corebus_sram.sv
// corebus memory target.
// one command at a time, byte-enabled writes, registered burst reads,
// error on words beyond the memory size.

`include "axi_corebus_consts.svh"

module corebus_sram
  import axi_corebus_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_cmd_valid,
  input  cb_cmd_t  i_cmd,
  output logic     o_cmd_accept,
  input  logic     i_data_valid,
  input  cb_data_t i_data,
  output logic     o_data_accept,
  output logic     o_resp_valid,
  output cb_resp_t o_resp,
  input  logic     i_resp_accept
);

  localparam int LEN_W  = `CB_LEN_W;
  localparam int WORD_W = `AXI_ADDR_W - 3;  // 8 bytes per word.
  localparam int MEM_AW = $clog2(`MEM_WORDS);
  localparam int NBYTES = `DATA_W / 8;

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} state_e;

  state_e               state;
  logic [`AXI_ID_W-1:0] cur_id;
  logic [WORD_W-1:0]    cur_word;
  logic [LEN_W-1:0]     beats_left;
  logic [LEN_W:0]       span;  // unit offset + length, rounded up to words.
  logic                 cmd_fire, data_fire, resp_load, in_range;
  logic [`DATA_W-1:0]   mem [`MEM_WORDS];

  assign o_cmd_accept  = state == ST_IDLE;
  assign o_data_accept = state == ST_WRITE;
  assign cmd_fire      = i_cmd_valid && o_cmd_accept;
  assign data_fire     = i_data_valid && o_data_accept;
  assign resp_load     = (state == ST_READ) && (!o_resp_valid || i_resp_accept);
  assign in_range      = cur_word < WORD_W'(`MEM_WORDS);
  assign span = (LEN_W+1)'(i_cmd.addr[2]) + (LEN_W+1)'(i_cmd.length) + (LEN_W+1)'(1);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= ST_IDLE;
      cur_id       <= '0;
      cur_word     <= '0;
      beats_left   <= '0;
      o_resp_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (cmd_fire) begin
          cur_id     <= i_cmd.id;
          cur_word   <= i_cmd.addr[`AXI_ADDR_W-1:3];
          beats_left <= span[LEN_W:1];
          state      <= (i_cmd.cmd == READ) ? ST_READ : ST_WRITE;
        end
        ST_READ: if (resp_load) begin
          cur_word   <= cur_word + WORD_W'(1);
          beats_left <= beats_left - LEN_W'(1);
          if (beats_left == LEN_W'(1)) state <= ST_IDLE;
        end
        ST_WRITE: if (data_fire) begin
          cur_word <= cur_word + WORD_W'(1);
          if (i_data.last) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
      if (resp_load) begin
        o_resp_valid <= 1'b1;
      end else if (i_resp_accept) begin
        o_resp_valid <= 1'b0;
      end
    end
  end

  // read beat register.
  always_ff @(posedge i_clk) begin
    if (resp_load) begin
      o_resp.id    <= cur_id;
      o_resp.data  <= in_range ? mem[cur_word[MEM_AW-1:0]] : '0;
      o_resp.error <= !in_range;
      o_resp.last  <= beats_left == LEN_W'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (data_fire && in_range) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (i_data.byteen[i]) mem[cur_word[MEM_AW-1:0]][8*i+:8] <= i_data.data[8*i+:8];
      end
    end
  end

endmodule

//--- src/axi_sram_subsystem.sv
// top level: axi to corebus bridge in front of the corebus memory.

module axi_sram_subsystem
  import axi_corebus_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_aw_valid,
  output logic    o_aw_ready,
  input  axi_ax_t i_aw,
  input  logic    i_w_valid,
  output logic    o_w_ready,
  input  axi_w_t  i_w,
  output logic    o_b_valid,
  input  logic    i_b_ready,
  output axi_b_t  o_b,
  input  logic    i_ar_valid,
  output logic    o_ar_ready,
  input  axi_ax_t i_ar,
  output logic    o_r_valid,
  input  logic    i_r_ready,
  output axi_r_t  o_r
);

  // corebus between bridge and memory.
  logic     cmd_valid, cmd_accept;
  cb_cmd_t  cmd;
  logic     data_valid, data_accept;
  cb_data_t data;
  logic     resp_valid, resp_accept;
  cb_resp_t resp;

  axi2corebus_bridge u_bridge (
    .i_clk, .i_rst_n,
    .i_aw_valid, .o_aw_ready, .i_aw,
    .i_w_valid, .o_w_ready, .i_w,
    .o_b_valid, .i_b_ready, .o_b,
    .i_ar_valid, .o_ar_ready, .i_ar,
    .o_r_valid, .i_r_ready, .o_r,
    .o_cmd_valid   (cmd_valid),
    .o_cmd         (cmd),
    .i_cmd_accept  (cmd_accept),
    .o_data_valid  (data_valid),
    .o_data        (data),
    .i_data_accept (data_accept),
    .i_resp_valid  (resp_valid),
    .i_resp        (resp),
    .o_resp_accept (resp_accept)
  );

  corebus_sram u_sram (
    .i_clk, .i_rst_n,
    .i_cmd_valid   (cmd_valid),
    .i_cmd         (cmd),
    .o_cmd_accept  (cmd_accept),
    .i_data_valid  (data_valid),
    .i_data        (data),
    .o_data_accept (data_accept),
    .o_resp_valid  (resp_valid),
    .o_resp        (resp),
    .i_resp_accept (resp_accept)
  );

endmodule

//--- tests/tb_axi_sram.sv
// testbench for the axi to corebus memory subsystem.
// axi drivers, shadow memory with a reference read function,
// a comparing process for r and b beats, and a cycle-count timeout.

`include "axi_corebus_consts.svh"

module tb_axi_sram
  import axi_corebus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RAND_SEED = 32'hc4039e5d;
  localparam int N_RANDOM = 60;
  localparam int MAX_LEN  = 7;
  // fill + readback, burst pair, 4-byte pair, eight writes, error read, random mix.
  localparam int TOTAL_BEATS = 2 * `MEM_WORDS + 16 + 2 + 8 + 4 + N_RANDOM * (MAX_LEN + 1);
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 200;

  localparam int READY_ON     = 0;
  localparam int READY_RANDOM = 1;
  localparam int HOLD_B       = 2;

  logic    i_clk = 1'b0;
  logic    i_rst_n;
  logic    i_aw_valid, o_aw_ready;
  axi_ax_t i_aw;
  logic    i_w_valid, o_w_ready;
  axi_w_t  i_w;
  logic    o_b_valid, i_b_ready;
  axi_b_t  o_b;
  logic    i_ar_valid, o_ar_ready;
  axi_ax_t i_ar;
  logic    o_r_valid, i_r_ready;
  axi_r_t  o_r;

  logic [`DATA_W-1:0]   shadow [`MEM_WORDS];
  axi_r_t               r_exp [$];
  logic [`AXI_ID_W-1:0] b_exp [$];
  axi_r_t               exp_r;
  logic [`AXI_ID_W-1:0] exp_bid;
  int                   ready_mode = READY_ON;
  int                   checks = 0;
  int                   errors = 0;

  always #50 i_clk = ~i_clk;

  axi_sram_subsystem i_axi_sram_subsystem (
    .i_clk, .i_rst_n,
    .i_aw_valid, .o_aw_ready, .i_aw,
    .i_w_valid, .o_w_ready, .i_w,
    .o_b_valid, .i_b_ready, .o_b,
    .i_ar_valid, .o_ar_ready, .i_ar,
    .o_r_valid, .i_r_ready, .o_r
  );

  //======================================================================
  // reference model.
  //======================================================================
  function automatic logic [`DATA_W-1:0] fill_pattern(input int word);
    logic [15:0] w;
    w = 16'(word);
    return {w ^ 16'hc3a5, ~w, w * 16'd7 + 16'd3, w};
  endfunction

  function automatic void apply_write(input int word, input logic [`DATA_W-1:0] data,
                                      input logic [`DATA_W/8-1:0] strb);
    int b;
    if (word < `MEM_WORDS) begin
      for (b = 0; b < `DATA_W / 8; b++) begin
        if (strb[b]) shadow[word][8*b+:8] = data[8*b+:8];
      end
    end
  endfunction

  // expected r beat for one 64-bit word.
  function automatic axi_r_t expect_beat(input logic [`AXI_ID_W-1:0] id, input int word,
                                         input logic last);
    axi_r_t r;
    r.id   = id;
    r.last = last;
    if (word < `MEM_WORDS) begin
      r.data = shadow[word];
      r.resp = OKAY;
    end else begin
      r.data = '0;  // beyond the memory.
      r.resp = SLVERR;
    end
    return r;
  endfunction

  //======================================================================
  // drivers.
  //======================================================================
  task automatic next_drive_slot();
    @(posedge i_clk);
    #1;
  endtask

  task automatic send_aw(input axi_ax_t ax);
    i_aw       = ax;
    i_aw_valid = 1'b1;
    @(negedge i_clk);
    while (!o_aw_ready) @(negedge i_clk);
    next_drive_slot();
    i_aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [`DATA_W-1:0] data, input logic [`DATA_W/8-1:0] strb,
                        input logic last);
    i_w.data  = data;
    i_w.strb  = strb;
    i_w.last  = last;
    i_w_valid = 1'b1;
    @(negedge i_clk);
    while (!o_w_ready) @(negedge i_clk);
    next_drive_slot();
    i_w_valid = 1'b0;
  endtask

  task automatic send_ar(input axi_ax_t ax);
    i_ar       = ax;
    i_ar_valid = 1'b1;
    @(negedge i_clk);
    while (!o_ar_ready) @(negedge i_clk);
    next_drive_slot();
    i_ar_valid = 1'b0;
  endtask

  task automatic write_burst(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_LEN_W-1:0] len, input logic [2:0] size,
                             input logic fill);
    axi_ax_t              ax;
    logic [`DATA_W-1:0]   data;
    logic [`DATA_W/8-1:0] strb;
    int                   word;
    int                   i;
    ax.id   = id;
    ax.addr = addr;
    ax.len  = len;
    ax.size = size;
    b_exp.push_back(id);
    send_aw(ax);
    for (i = 0; i <= int'(len); i++) begin
      word = int'(addr[`AXI_ADDR_W-1:3]) + i;
      if (fill) begin
        data = fill_pattern(word);
        strb = '1;
      end else begin
        data = {$urandom, $urandom};
        strb = 8'($urandom);
      end
      if (size == 3'd2) begin
        strb = addr[2] ? 8'hf0 : 8'h0f;
      end else if (i == 0 && addr[2]) begin
        strb = strb & 8'hf0;  // burst starts in the upper unit.
      end
      apply_write(word, data, strb);
      send_w(data, strb, i == int'(len));
    end
  endtask

  task automatic read_burst(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
                            input logic [`AXI_LEN_W-1:0] len, input logic [2:0] size);
    axi_ax_t ax;
    int      i;
    ax.id   = id;
    ax.addr = addr;
    ax.len  = len;
    ax.size = size;
    for (i = 0; i <= int'(len); i++) begin
      r_exp.push_back(expect_beat(id, int'(addr[`AXI_ADDR_W-1:3]) + i, i == int'(len)));
    end
    send_ar(ax);
  endtask

  task automatic wait_reads_done();
    while (r_exp.size() != 0) next_drive_slot();
  endtask

  task automatic wait_writes_done();
    while (b_exp.size() != 0) next_drive_slot();
  endtask

  // response ready lines, one step behind the channel drivers.
  always begin
    @(posedge i_clk);
    #2;
    case (ready_mode)
      READY_RANDOM: begin
        i_r_ready = ($urandom % 4) != 0;
        i_b_ready = ($urandom % 3) != 0;
      end
      HOLD_B: begin
        i_r_ready = 1'b1;
        i_b_ready = 1'b0;
      end
      default: begin
        i_r_ready = 1'b1;
        i_b_ready = 1'b1;
      end
    endcase
  end

  //======================================================================
  // checking.
  //======================================================================
  task automatic compare_value(input string name, input logic [`DATA_W-1:0] got,
                               input logic [`DATA_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %0d ns, %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // handshakes are sampled mid-cycle and complete on the next rising edge.
  always @(negedge i_clk) begin
    if (i_rst_n && o_r_valid && i_r_ready) begin
      assert (r_exp.size() != 0) else begin
        errors++;
        $display("Error: %0d ns, R beat with id %h came with no read outstanding", $time, o_r.id);
      end
      if (r_exp.size() != 0) begin
        exp_r = r_exp.pop_front();
        compare_value("o_r.id", o_r.id, exp_r.id);
        compare_value("o_r.data", o_r.data, exp_r.data);
        compare_value("o_r.resp", o_r.resp, exp_r.resp);
        compare_value("o_r.last", o_r.last, exp_r.last);
      end
    end
    if (i_rst_n && o_b_valid && i_b_ready) begin
      assert (b_exp.size() != 0) else begin
        errors++;
        $display("Error: %0d ns, B with id %h came with no write outstanding", $time, o_b.id);
      end
      if (b_exp.size() != 0) begin
        exp_bid = b_exp.pop_front();
        compare_value("o_b.id", o_b.id, exp_bid);
        compare_value("o_b.resp", o_b.resp, OKAY);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d read beats and %0d write responses never came",
             cycles, r_exp.size(), b_exp.size());
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  //======================================================================
  // test sequence.
  //======================================================================
  initial begin : main_seq
    int                     i;
    int                     len;
    int                     word;
    int                     off;
    logic [2:0]             size;
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    void'($urandom(RAND_SEED));
    i_rst_n    = 1'b0;
    i_aw_valid = 1'b0;
    i_aw       = '0;
    i_w_valid  = 1'b0;
    i_w        = '0;
    i_b_ready  = 1'b0;
    i_ar_valid = 1'b0;
    i_ar       = '0;
    i_r_ready  = 1'b0;
    repeat (9) @(posedge i_clk);
    @(negedge i_clk);
    compare_value("o_aw_ready", o_aw_ready, 1'b0);
    compare_value("o_w_ready", o_w_ready, 1'b0);
    compare_value("o_ar_ready", o_ar_ready, 1'b0);
    @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    // idle after reset, channels ready one cycle after release.
    for (i = 0; i < 5; i++) begin
      @(negedge i_clk);
      compare_value("o_b_valid", o_b_valid, 1'b0);
      compare_value("o_r_valid", o_r_valid, 1'b0);
      compare_value("o_aw_ready", o_aw_ready, i != 0);
      compare_value("o_w_ready", o_w_ready, i != 0);
      compare_value("o_ar_ready", o_ar_ready, i != 0);
    end
    next_drive_slot();

    // fill the whole memory, then read it back in one burst.
    write_burst(4'h0, 16'h0000, 8'd255, 3'd3, 1'b1);
    wait_writes_done();
    read_burst(4'h1, 16'h0000, 8'd255, 3'd3);
    wait_reads_done();

    write_burst(4'h2, 16'h0040, 8'd7, 3'd3, 1'b0);
    wait_writes_done();
    read_burst(4'h3, 16'h0040, 8'd7, 3'd3);
    wait_reads_done();

    // 4-byte access to the upper lane.
    write_burst(4'h4, 16'h0124, 8'd0, 3'd2, 1'b0);
    wait_writes_done();
    read_burst(4'h5, 16'h0124, 8'd0, 3'd2);
    wait_reads_done();

    // eight writes outstanding before any b is taken.
    ready_mode = HOLD_B;
    for (i = 0; i < 8; i++) begin
      write_burst(4'(15 - i), 16'(16'h0200 + 8 * i), 8'd0, 3'd3, 1'b0);
    end
    repeat (4) next_drive_slot();
    ready_mode = READY_ON;
    wait_writes_done();

    read_burst(4'h6, 16'h0810, 8'd3, 3'd3);  // past the memory end.
    wait_reads_done();

    ready_mode = READY_RANDOM;
    for (i = 0; i < N_RANDOM; i++) begin
      len  = $urandom_range(0, MAX_LEN);
      word = $urandom_range(0, `MEM_WORDS - 1 - len);
      off  = $urandom_range(0, 1);
      addr = 16'(8 * word + 4 * off);
      size = (len == 0 && ($urandom % 3) == 0) ? 3'd2 : 3'd3;
      id   = 4'($urandom);
      if (($urandom % 2) != 0) begin
        wait_reads_done();
        write_burst(id, addr, 8'(len), size, 1'b0);
      end else begin
        wait_writes_done();
        read_burst(id, addr, 8'(len), size);
      end
    end
    ready_mode = READY_ON;
    wait_reads_done();
    wait_writes_done();
    repeat (5) next_drive_slot();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
src/axi_corebus_pkg.sv
src/bus_fifo.sv
src/corebus_cmd_arbiter.sv
src/axi2corebus_bridge.sv
src/corebus_sram.sv
src/axi_sram_subsystem.sv
tests/tb_axi_sram.sv

//--- Bender.yml
package:
  name: axi_sram_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/axi_corebus_pkg.sv
      - src/bus_fifo.sv
      - src/corebus_cmd_arbiter.sv
      - src/axi2corebus_bridge.sv
      - src/corebus_sram.sv
      - src/axi_sram_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_axi_sram.sv
